/* bench/tb_pat_fetch.sv */
`timescale 1ns/100ps

module tb_pat_fetch;
    import pat_fetch_pkg::*;

    localparam int LINES        = 6;
    localparam int PIX_LINE     = 80;
    localparam int DE_LEN       = 82;
    localparam int GAP_LEN      = 40;
    localparam int HS_LEN       = 8;
    localparam int FRAME_CYCLES = 14 + LINES * (GAP_LEN + DE_LEN);
    localparam int MEM_DEPTH    = 2 ** MEM_ADDR_W;
    // two runs of 3 and 2 frames plus polling, busy holds and quiet gaps
    localparam int TIMEOUT_NS   = 4 * ((3 + 2) * FRAME_CYCLES + 3000);

    logic                  clk                     = 1'b0;
    logic                  ddr3_emif_rst_n         = 1'b0;
    logic [MEM_DATA_W-1:0] mem_read_data           = '0;
    logic                  frame_busy              = 1'b1;
    logic                  h_sync_in               = 1'b0;
    logic                  v_sync_in               = 1'b0;
    logic                  de_in                   = 1'b0;
    logic                  de_first_offset_line_in = 1'b0;
    logic [PIX_W-1:0]      left_offset_in          = '0;

    logic                  mem_read;
    logic                  mem_write;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [MEM_DATA_W-1:0] mem_write_data;
    logic [MEM_BE_W-1:0]   mem_byte_enable;
    logic                  frame_trig;
    logic                  h_sync_out;
    logic                  v_sync_out;
    logic                  de_out;
    logic [PIX_W-1:0]      pix_data_out;

    // memory model with the header word kept apart from the pattern store
    logic [MEM_DATA_W-1:0] pattern_mem [MEM_DEPTH];
    logic [MEM_DATA_W-1:0] hdr_mem  = '0;
    logic [MEM_DATA_W-1:0] rd_stage = '0;
    logic                  hdr_load = 1'b0;
    logic [MEM_DATA_W-1:0] hdr_word = '0;

    // inputs one cycle back for the output monitor
    logic             h_sync_d = 1'b0;
    logic             v_sync_d = 1'b0;
    logic             de_d     = 1'b0;
    logic             offset_d = 1'b0;
    logic             busy_d   = 1'b0;
    logic [PIX_W-1:0] left_d   = '0;

    int mon_errs   = 0;
    int run_errs   = 0;
    int trig_total = 0;
    int write_cnt  = 0;
    int run_trigs  = 0;
    int pix_n      = 0;
    int line_pix   = 0;
    int fetch_next = 1;

    pat_fetch_top #(
        .LINES_PER_FRAME (LINES),
        .PIX_PER_LINE    (PIX_LINE)
    ) i_pat_fetch_top (
        .clk                     (clk),
        .ddr3_emif_rst_n         (ddr3_emif_rst_n),
        .mem_read_data           (mem_read_data),
        .frame_busy              (frame_busy),
        .h_sync_in               (h_sync_in),
        .v_sync_in               (v_sync_in),
        .de_in                   (de_in),
        .de_first_offset_line_in (de_first_offset_line_in),
        .left_offset_in          (left_offset_in),
        .mem_read                (mem_read),
        .mem_write               (mem_write),
        .mem_addr                (mem_addr),
        .mem_write_data          (mem_write_data),
        .mem_byte_enable         (mem_byte_enable),
        .frame_trig              (frame_trig),
        .h_sync_out              (h_sync_out),
        .v_sync_out              (v_sync_out),
        .de_out                  (de_out),
        .pix_data_out            (pix_data_out)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // reference helpers
    // ------------------------------------------------------------
    function automatic logic [MEM_DATA_W-1:0] header_word(input int total);
        logic [MEM_DATA_W-1:0] w;
        w        = '0;
        w[63:32] = total;
        w[7:0]   = MAGIC_MEM;
        return w;
    endfunction

    // expand byte enables so the top enable bit covers the top byte
    function automatic logic [MEM_DATA_W-1:0] byte_mask(input logic [MEM_BE_W-1:0] be);
        logic [MEM_DATA_W-1:0] m;
        logic [MEM_BE_W-1:0]   b;
        m = '0;
        b = be;
        repeat (MEM_BE_W) begin
            m = {m[MEM_DATA_W-9:0], {8{b[MEM_BE_W-1]}}};
            b = b << 1;
        end
        return m;
    endfunction

    // pixel n of a run comes from block n/32 in words 1+3b..3+3b with word 0 on top
    function automatic logic [PIX_W-1:0] model_pixel(input int n);
        logic [3*MEM_DATA_W-1:0] blk;
        int                      b;
        int                      p;
        b   = n / 32;
        p   = n % 32;
        blk = {pattern_mem[MEM_ADDR_W'(1 + 3 * b)], pattern_mem[MEM_ADDR_W'(2 + 3 * b)],
               pattern_mem[MEM_ADDR_W'(3 + 3 * b)]};
        blk = blk << (PIX_W * p);
        return blk[3*MEM_DATA_W-1 -: PIX_W];
    endfunction

    // ------------------------------------------------------------
    // memory with two-cycle read pipeline
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (hdr_load) begin
            hdr_mem <= hdr_word;
        end else if (mem_write && mem_addr == '0) begin
            hdr_mem <= (hdr_mem & ~byte_mask(mem_byte_enable)) |
                       (mem_write_data & byte_mask(mem_byte_enable));
        end
        // data only comes back for a read strobe
        if (!mem_read) begin
            rd_stage <= '0;
        end else if (mem_addr == '0) begin
            rd_stage <= hdr_mem;
        end else begin
            rd_stage <= pattern_mem[mem_addr];
        end
        mem_read_data <= rd_stage;
    end

    // ------------------------------------------------------------
    // output monitor
    // ------------------------------------------------------------
    always @(posedge clk) begin : out_mon
        logic [PIX_W-1:0] expected;
        h_sync_d <= h_sync_in;
        v_sync_d <= v_sync_in;
        de_d     <= de_in;
        offset_d <= de_first_offset_line_in;
        left_d   <= left_offset_in;
        busy_d   <= frame_busy;
        if (ddr3_emif_rst_n) begin
            if (h_sync_out !== h_sync_d || v_sync_out !== v_sync_d || de_out !== de_d) begin
                mon_errs++;
                $display("mismatch at %0t: h/v/de out %b%b%b, expected %b%b%b", $time,
                         h_sync_out, v_sync_out, de_out, h_sync_d, v_sync_d, de_d);
            end
            if (!de_out) begin
                expected = '0;
                line_pix = 0;
            end else if (offset_d) begin
                expected = left_d;
            end else if (line_pix < PIX_LINE) begin
                expected = model_pixel(pix_n);
                pix_n++;
                line_pix++;
            end else begin
                expected = '0;
            end
            if (pix_data_out !== expected) begin
                mon_errs++;
                $display("mismatch at %0t: pixel %0d is %h, expected %h", $time,
                         pix_n, pix_data_out, expected);
            end
            if (frame_trig) begin
                if (run_trigs == 0 && busy_d) begin
                    mon_errs++;
                    $display("first frame_trig at %0t came while frame_busy was high", $time);
                end
                run_trigs++;
                trig_total++;
            end
            if (mem_read && mem_write) begin
                mon_errs++;
                $display("memory read and write were both strobed at %0t", $time);
            end
            // pattern reads walk up from address 1 within a run
            if (mem_read && mem_addr != '0) begin
                if (mem_addr !== MEM_ADDR_W'(fetch_next)) begin
                    mon_errs++;
                    $display("mismatch at %0t: fetch read from %h, expected %h", $time,
                             mem_addr, MEM_ADDR_W'(fetch_next));
                end
                fetch_next = int'(mem_addr) + 1;
            end
            if (mem_write) begin
                if (mem_addr !== '0 || mem_write_data !== '0 || mem_byte_enable !== '1) begin
                    mon_errs++;
                    $display("mismatch at %0t: clear write addr %h data %h be %h", $time,
                             mem_addr, mem_write_data, mem_byte_enable);
                end
                // next run starts again at pixel 0 and address 1
                write_cnt++;
                run_trigs  = 0;
                pix_n      = 0;
                fetch_next = 1;
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic fill_patterns();
        logic [MEM_DATA_W-1:0] w;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            w = '0;
            repeat (MEM_DATA_W / 32) begin
                w = {w[MEM_DATA_W-33:0], $urandom};
            end
            pattern_mem[MEM_ADDR_W'(a)] = w;
        end
    endtask

    task automatic check_idle();
        if (frame_trig !== 1'b0 || mem_write !== 1'b0 || de_out !== 1'b0 ||
            pix_data_out !== '0) begin
            run_errs++;
            $display("mismatch at %0t: outputs not idle near reset, trig %b write %b de %b pix %h",
                     $time, frame_trig, mem_write, de_out, pix_data_out);
        end
    endtask

    task automatic wait_trig();
        do begin
            @(posedge clk);
        end while (frame_trig !== 1'b1);
    endtask

    // v_sync pulse then one offset line and five pixel lines
    task automatic drive_frame();
        left_offset_in <= PIX_W'($urandom);
        v_sync_in      <= 1'b1;
        repeat (4) @(posedge clk);
        v_sync_in <= 1'b0;
        repeat (10) @(posedge clk);
        for (int ln = 0; ln < LINES; ln++) begin
            h_sync_in <= 1'b1;
            repeat (HS_LEN) @(posedge clk);
            h_sync_in <= 1'b0;
            repeat (GAP_LEN - HS_LEN) @(posedge clk);
            de_in                   <= 1'b1;
            de_first_offset_line_in <= (ln == 0);
            repeat (DE_LEN) @(posedge clk);
            de_in                   <= 1'b0;
            de_first_offset_line_in <= 1'b0;
        end
    endtask

    task automatic run_patterns(input int total);
        int hold;
        int trig_base;
        int write_base;
        @(negedge clk);
        trig_base  = trig_total;
        write_base = write_cnt;
        hold       = 20 + int'($urandom % 60);
        @(posedge clk);
        frame_busy <= 1'b1;
        hdr_word   <= header_word(total);
        hdr_load   <= 1'b1;
        @(posedge clk);
        hdr_load <= 1'b0;
        repeat (hold) @(posedge clk);
        frame_busy <= 1'b0;
        for (int f = 0; f < total; f++) begin
            wait_trig();
            drive_frame();
        end
        @(negedge clk);
        while (write_cnt == write_base) @(negedge clk);
        // nothing may start in the quiet time without a new header
        repeat (300) @(negedge clk);
        if (trig_total - trig_base != total) begin
            run_errs++;
            $display("run with %0d patterns gave %0d frame_trig pulses", total,
                     trig_total - trig_base);
        end
        if (write_cnt - write_base != 1) begin
            run_errs++;
            $display("run with %0d patterns ended with %0d memory writes", total,
                     write_cnt - write_base);
        end
    endtask

    initial begin
        void'($urandom(32'h2f13c9bf));
        fill_patterns();
        repeat (5) @(posedge clk);
        check_idle();
        ddr3_emif_rst_n <= 1'b1;
        @(negedge clk);
        check_idle();
        @(negedge clk);
        check_idle();
        run_patterns(3);
        run_patterns(2);
        $display("error count: %0d from the output monitor, %0d from the run checks",
                 mon_errs, run_errs);
        if (mon_errs == 0 && run_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* pat_fetch_top.f */
verilog/pat_fetch_pkg.sv
verilog/fetch_if.sv
verilog/pat_seq_fsm.sv
verilog/line_counter.sv
verilog/mem_block_reader.sv
verilog/pixel_serializer.sv
verilog/pat_fetch_top.sv
bench/tb_pat_fetch.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the pattern fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_pat_fetch -Mdir obj_dir -o tb_pat_fetch \
    -f pat_fetch_top.f

./obj_dir/tb_pat_fetch > sim.log 2>&1
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

/* verilog/fetch_if.sv */
`timescale 1ns/100ps

interface fetch_if;
    import pat_fetch_pkg::*;

    // reader side, from the header poll
    logic                 header_seen;
    logic [PAT_CNT_W-1:0] pattern_total;

    // sequencer side
    logic                 fetch_go;
    logic                 clear_req;

    modport seq (
        input  header_seen,
        input  pattern_total,
        output fetch_go,
        output clear_req
    );

    modport reader (
        output header_seen,
        output pattern_total,
        input  fetch_go,
        input  clear_req
    );

endinterface

/* verilog/line_counter.sv */
`timescale 1ns/100ps

module line_counter #(
    parameter int LINES_PER_FRAME = 1081
) (
    input  logic clk,
    input  logic ddr3_emif_rst_n,
    input  logic v_sync_in,
    input  logic de_in,
    output logic frame_done
);
    localparam int LC_W = $clog2(LINES_PER_FRAME + 1);

    logic            v_sync_d;
    logic            de_d;
    logic            de_fall;
    logic [LC_W-1:0] line_cnt;

    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            v_sync_d   <= 1'b0;
            de_d       <= 1'b0;
            de_fall    <= 1'b0;
            line_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            v_sync_d <= v_sync_in;
            de_d     <= de_in;
            de_fall  <= de_d & ~de_in;
            // v_sync restarts the count, every de rise is a new line
            if (v_sync_in && !v_sync_d) begin
                line_cnt <= '0;
            end else if (de_in && !de_d) begin
                line_cnt <= line_cnt + LC_W'(1);
            end
            frame_done <= de_fall && (line_cnt == LC_W'(LINES_PER_FRAME));
        end
    end

endmodule

/* verilog/mem_block_reader.sv */
`timescale 1ns/100ps

module mem_block_reader (
    input  logic                                 clk,
    input  logic                                 ddr3_emif_rst_n,
    fetch_if.reader                              ctl,
    input  logic [pat_fetch_pkg::MEM_DATA_W-1:0] mem_read_data,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [pat_fetch_pkg::MEM_ADDR_W-1:0] mem_addr,
    output logic [pat_fetch_pkg::MEM_DATA_W-1:0] mem_write_data,
    output logic [pat_fetch_pkg::MEM_BE_W-1:0]   mem_byte_enable,
    output logic                                 block_valid,
    output pat_fetch_pkg::pix_block_u            block,
    input  logic                                 block_ready
);
    import pat_fetch_pkg::*;

    localparam int WCNT_W = $clog2(WORDS_PER_BLOCK + 1);

    logic [MEM_ADDR_W-1:0]     fetch_addr;
    logic                      rd_is_fetch;
    logic [MEM_RD_LATENCY-1:0] poll_pipe;
    logic [MEM_RD_LATENCY-1:0] fetch_pipe;
    logic [WCNT_W-1:0]         words_issued;
    logic [WCNT_W-1:0]         words_back;
    logic                      xfer;
    logic                      issue_poll;
    logic                      issue_fetch;
    logic                      fetch_ret;
    logic                      hdr_match;

    // the only write is the header clear
    assign mem_write_data = '0;

    assign xfer        = block_valid & block_ready;
    assign issue_poll  = ~ctl.fetch_go & ~ctl.clear_req;
    // at most one block issued ahead of the one handed over
    assign issue_fetch = ctl.fetch_go &
                         ((words_issued != WCNT_W'(WORDS_PER_BLOCK)) | xfer);
    assign fetch_ret   = fetch_pipe[MEM_RD_LATENCY-1];
    assign hdr_match   = poll_pipe[MEM_RD_LATENCY-1] & (mem_read_data[7:0] == MAGIC_MEM) &
                         ~ctl.fetch_go & ~ctl.header_seen;

    // ------------------------------------------------------------
    // read issue, return tagging and clear write
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            mem_read          <= 1'b0;
            mem_write         <= 1'b0;
            mem_addr          <= '0;
            mem_byte_enable   <= '0;
            rd_is_fetch       <= 1'b0;
            fetch_addr        <= MEM_ADDR_W'(1);
            poll_pipe         <= '0;
            fetch_pipe        <= '0;
            words_issued      <= '0;
            words_back        <= '0;
            block_valid       <= 1'b0;
            ctl.header_seen   <= 1'b0;
            ctl.pattern_total <= '0;
        end else begin
            mem_write       <= 1'b0;
            mem_byte_enable <= '0;
            ctl.header_seen <= hdr_match;
            if (hdr_match) begin
                ctl.pattern_total <= mem_read_data[HDR_TOTAL_LSB +: PAT_CNT_W];
            end
            if (ctl.clear_req) begin
                // drop everything in flight, zero the header word
                mem_read        <= 1'b0;
                mem_write       <= 1'b1;
                mem_addr        <= '0;
                mem_byte_enable <= '1;
                fetch_addr      <= MEM_ADDR_W'(1);
                poll_pipe       <= '0;
                fetch_pipe      <= '0;
                words_issued    <= '0;
                words_back      <= '0;
                block_valid     <= 1'b0;
            end else begin
                poll_pipe   <= {poll_pipe[MEM_RD_LATENCY-2:0], mem_read & ~rd_is_fetch};
                fetch_pipe  <= {fetch_pipe[MEM_RD_LATENCY-2:0], mem_read & rd_is_fetch};
                mem_read    <= issue_poll | issue_fetch;
                rd_is_fetch <= issue_fetch;
                if (issue_fetch) begin
                    mem_addr   <= fetch_addr;
                    fetch_addr <= fetch_addr + MEM_ADDR_W'(1);
                end else begin
                    mem_addr <= '0;
                end
                if (xfer) begin
                    words_issued <= issue_fetch ? WCNT_W'(1) : '0;
                    block_valid  <= 1'b0;
                end else if (issue_fetch) begin
                    words_issued <= words_issued + WCNT_W'(1);
                end
                if (fetch_ret) begin
                    if (words_back == WCNT_W'(WORDS_PER_BLOCK - 1)) begin
                        words_back  <= '0;
                        block_valid <= 1'b1;
                    end else begin
                        words_back <= words_back + WCNT_W'(1);
                    end
                end
            end
        end
    end

    // staging block, word 0 first
    always_ff @(posedge clk) begin
        if (fetch_ret && !ctl.clear_req) begin
            block.word[words_back] <= mem_read_data;
        end
    end

endmodule

/* verilog/pat_fetch_pkg.sv */
package pat_fetch_pkg;

    // ------------------------------------------------------------
    // on-chip memory
    // ------------------------------------------------------------
    localparam int MEM_DATA_W      = 256;
    localparam int MEM_ADDR_W      = 13;
    localparam int MEM_BE_W        = 32;
    // read strobe to data valid, in clk cycles
    localparam int MEM_RD_LATENCY  = 2;

    // header word at address 0
    localparam logic [7:0] MAGIC_MEM = 8'h55;
    localparam int HDR_TOTAL_LSB   = 32;
    localparam int PAT_CNT_W       = 32;

    // ------------------------------------------------------------
    // pixel blocks
    // ------------------------------------------------------------
    localparam int PIX_W           = 24;
    localparam int WORDS_PER_BLOCK = 3;
    localparam int PIX_PER_BLOCK   = 32;

    // filled as three memory words, drained as 32 pixels
    // index 0 of either view sits in the top bits
    typedef union packed {
        logic [0:WORDS_PER_BLOCK-1][MEM_DATA_W-1:0] word;
        logic [0:PIX_PER_BLOCK-1][PIX_W-1:0]        pix;
    } pix_block_u;

endpackage

/* verilog/pat_fetch_top.sv */
`timescale 1ns/100ps

module pat_fetch_top #(
    parameter int LINES_PER_FRAME = 1081,
    parameter int PIX_PER_LINE    = 80
) (
    input  logic                                 clk,
    input  logic                                 ddr3_emif_rst_n,
    input  logic [pat_fetch_pkg::MEM_DATA_W-1:0] mem_read_data,
    input  logic                                 frame_busy,
    input  logic                                 h_sync_in,
    input  logic                                 v_sync_in,
    input  logic                                 de_in,
    input  logic                                 de_first_offset_line_in,
    input  logic [pat_fetch_pkg::PIX_W-1:0]      left_offset_in,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [pat_fetch_pkg::MEM_ADDR_W-1:0] mem_addr,
    output logic [pat_fetch_pkg::MEM_DATA_W-1:0] mem_write_data,
    output logic [pat_fetch_pkg::MEM_BE_W-1:0]   mem_byte_enable,
    output logic                                 frame_trig,
    output logic                                 h_sync_out,
    output logic                                 v_sync_out,
    output logic                                 de_out,
    output logic [pat_fetch_pkg::PIX_W-1:0]      pix_data_out
);
    import pat_fetch_pkg::*;

    pix_block_u block;
    logic       block_valid;
    logic       block_ready;
    logic       frame_done;

    fetch_if ctl ();

    pat_seq_fsm i_pat_seq_fsm (
        .clk             (clk),
        .ddr3_emif_rst_n (ddr3_emif_rst_n),
        .ctl             (ctl.seq),
        .block_valid     (block_valid),
        .frame_busy      (frame_busy),
        .frame_done      (frame_done),
        .frame_trig      (frame_trig)
    );

    line_counter #(
        .LINES_PER_FRAME (LINES_PER_FRAME)
    ) i_line_counter (
        .clk             (clk),
        .ddr3_emif_rst_n (ddr3_emif_rst_n),
        .v_sync_in       (v_sync_in),
        .de_in           (de_in),
        .frame_done      (frame_done)
    );

    mem_block_reader i_mem_block_reader (
        .clk             (clk),
        .ddr3_emif_rst_n (ddr3_emif_rst_n),
        .ctl             (ctl.reader),
        .mem_read_data   (mem_read_data),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_write_data  (mem_write_data),
        .mem_byte_enable (mem_byte_enable),
        .block_valid     (block_valid),
        .block           (block),
        .block_ready     (block_ready)
    );

    pixel_serializer #(
        .PIX_PER_LINE (PIX_PER_LINE)
    ) i_pixel_serializer (
        .clk                     (clk),
        .ddr3_emif_rst_n         (ddr3_emif_rst_n),
        .fetch_go                (ctl.fetch_go),
        .block_valid             (block_valid),
        .block                   (block),
        .block_ready             (block_ready),
        .h_sync_in               (h_sync_in),
        .v_sync_in               (v_sync_in),
        .de_in                   (de_in),
        .de_first_offset_line_in (de_first_offset_line_in),
        .left_offset_in          (left_offset_in),
        .h_sync_out              (h_sync_out),
        .v_sync_out              (v_sync_out),
        .de_out                  (de_out),
        .pix_data_out            (pix_data_out)
    );

endmodule

/* verilog/pat_seq_fsm.sv */
`timescale 1ns/100ps

module pat_seq_fsm (
    input  logic clk,
    input  logic ddr3_emif_rst_n,
    fetch_if.seq ctl,
    input  logic block_valid,
    input  logic frame_busy,
    input  logic frame_done,
    output logic frame_trig
);
    import pat_fetch_pkg::*;

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] PRELOAD = 2'd1;
    localparam logic [1:0] SEND    = 2'd2;
    localparam logic [1:0] CLEAR   = 2'd3;

    logic [1:0]           state;
    logic [PAT_CNT_W-1:0] total;
    logic [PAT_CNT_W-1:0] frames_shown;
    logic                 last_frame;

    // the frame now ending is the last one of the run
    assign last_frame = (frames_shown + PAT_CNT_W'(1)) >= total;

    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            state         <= IDLE;
            total         <= '0;
            frames_shown  <= '0;
            ctl.fetch_go  <= 1'b0;
            ctl.clear_req <= 1'b0;
            frame_trig    <= 1'b0;
        end else begin
            frame_trig    <= 1'b0;
            ctl.clear_req <= 1'b0;
            case (state)
                IDLE: begin
                    if (ctl.header_seen) begin
                        total        <= ctl.pattern_total;
                        frames_shown <= '0;
                        ctl.fetch_go <= 1'b1;
                        state        <= PRELOAD;
                    end
                end
                PRELOAD: begin
                    // first block staged, wait for the display side
                    if (block_valid && !frame_busy) begin
                        frame_trig <= 1'b1;
                        state      <= SEND;
                    end
                end
                SEND: begin
                    if (frame_done) begin
                        if (last_frame) begin
                            ctl.fetch_go  <= 1'b0;
                            ctl.clear_req <= 1'b1;
                            state         <= CLEAR;
                        end else begin
                            frames_shown <= frames_shown + PAT_CNT_W'(1);
                            frame_trig   <= 1'b1;
                        end
                    end
                end
                CLEAR: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/pixel_serializer.sv */
`timescale 1ns/100ps

module pixel_serializer #(
    parameter int PIX_PER_LINE = 80
) (
    input  logic                            clk,
    input  logic                            ddr3_emif_rst_n,
    input  logic                            fetch_go,
    input  logic                            block_valid,
    input  pat_fetch_pkg::pix_block_u       block,
    output logic                            block_ready,
    input  logic                            h_sync_in,
    input  logic                            v_sync_in,
    input  logic                            de_in,
    input  logic                            de_first_offset_line_in,
    input  logic [pat_fetch_pkg::PIX_W-1:0] left_offset_in,
    output logic                            h_sync_out,
    output logic                            v_sync_out,
    output logic                            de_out,
    output logic [pat_fetch_pkg::PIX_W-1:0] pix_data_out
);
    import pat_fetch_pkg::*;

    localparam int IDX_W  = $clog2(PIX_PER_BLOCK);
    localparam int DCNT_W = $clog2(PIX_PER_LINE + 1);

    pix_block_u        cur_block;
    logic              full;
    logic [IDX_W-1:0]  pix_idx;
    logic [DCNT_W-1:0] de_cnt;
    logic              in_run;
    logic              take_pix;
    logic              last_pix;

    // a pixel is owed on a normal line until PIX_PER_LINE are out
    assign in_run      = de_in & ~de_first_offset_line_in & (de_cnt < DCNT_W'(PIX_PER_LINE));
    assign take_pix    = in_run & full;
    assign last_pix    = take_pix & (pix_idx == IDX_W'(PIX_PER_BLOCK - 1));
    assign block_ready = ~full | last_pix;

    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            full         <= 1'b0;
            pix_idx      <= '0;
            de_cnt       <= '0;
            h_sync_out   <= 1'b0;
            v_sync_out   <= 1'b0;
            de_out       <= 1'b0;
            pix_data_out <= '0;
        end else begin
            h_sync_out <= h_sync_in;
            v_sync_out <= v_sync_in;
            de_out     <= de_in;

            if (!de_in) begin
                de_cnt <= '0;
            end else if (in_run) begin
                de_cnt <= de_cnt + DCNT_W'(1);
            end

            // index carries over lines and frames, only a stopped run restarts it
            if (!fetch_go) begin
                full    <= 1'b0;
                pix_idx <= '0;
            end else begin
                if (take_pix) begin
                    pix_idx <= pix_idx + IDX_W'(1);
                end
                if (block_valid && block_ready) begin
                    full <= 1'b1;
                end else if (last_pix) begin
                    full <= 1'b0;
                end
            end

            // underrun falls through to zero
            if (de_in && de_first_offset_line_in) begin
                pix_data_out <= left_offset_in;
            end else if (take_pix) begin
                pix_data_out <= cur_block.pix[pix_idx];
            end else begin
                pix_data_out <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (block_valid && block_ready) begin
            cur_block <= block;
        end
    end

endmodule
